// ==== design/core_isa_pkg.sv ====
// --------------------------------------------------
// RV32 opcodes, funct7 and funct3 codes
// Instruction word union with R and I views
// --------------------------------------------------
`default_nettype none

package core_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct7 groups under OPC_OP
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Integer funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Divide funct3 codes, upper half of the M group
    localparam logic [2:0] F3_DIV  = 3'b100;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REM  = 3'b110;
    localparam logic [2:0] F3_REMU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32-bit word seen as R type or I type
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

endpackage

`default_nettype wire

// ==== design/core_exec_pkg.sv ====
// --------------------------------------------------
// Unit select, ALU and divide operation codes
// Decoded issue record
// --------------------------------------------------
`default_nettype none

package core_exec_pkg;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_DIV = 1'b1
    } unit_id_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // Low two bits of the unit op field
    typedef struct packed {
        logic is_signed;
        logic is_rem;
    } div_op_t;

    // Held by the control FSM from decode to writeback
    typedef struct packed {
        unit_id_t    unit;
        alu_op_t     alu_op;
        div_op_t     div_op;
        logic        use_imm;
        logic [4:0]  rd;
        logic [31:0] imm;
    } issue_t;

endpackage

`default_nettype wire

// ==== design/exec_ifs.sv ====
// --------------------------------------------------
// Functional unit execute interface
// Register file access interface
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface func_unit_ex_if #(
    parameter int XLEN = 32
);
    logic            new_request;
    logic [3:0]      op;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            ready;
    logic            done;
    logic [XLEN-1:0] result;

    // Control side, pulses new_request only while ready
    modport issue (
        output new_request, op, rs1_data, rs2_data,
        input  ready, done, result
    );

    // Unit side, done is a one-cycle pulse with result valid
    modport unit (
        input  new_request, op, rs1_data, rs2_data,
        output ready, done, result
    );
endinterface

interface rf_if #(
    parameter int XLEN = 32
);
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            we;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;

    modport ctrl (output rs1_addr, rs2_addr, we, rd, wdata, input rs1_data, rs2_data);
    modport rf (input rs1_addr, rs2_addr, we, rd, wdata, output rs1_data, rs2_data);
endinterface

`default_nettype wire

// ==== design/iteration_timer.sv ====
// --------------------------------------------------
// Loadable down-counter, flags the final iteration
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iteration_timer #(
    parameter int LENGTH = 32
) (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    output logic last,
    output logic busy
);
    localparam int CW = (LENGTH > 1) ? $clog2(LENGTH) : 1;

    logic [CW-1:0] count;

    // Runs LENGTH cycles after the load edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (load) begin
            busy  <= 1'b1;
            count <= CW'(LENGTH - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign last = busy && (count == '0);

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
// --------------------------------------------------
// 32 x XLEN integer register file
// Two async read ports, one clocked write port
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int XLEN = 32
) (
    input  logic clk,
    input  logic rst_n,
    rf_if.rf     rf
);
    logic [XLEN-1:0] regs [32];

    // x0 stays zero since it is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && (rf.rd != 5'd0)) begin
            regs[rf.rd] <= rf.wdata;
        end
    end

    // Write shows up on reads the next cycle
    assign rf.rs1_data = regs[rf.rs1_addr];
    assign rf.rs2_data = regs[rf.rs2_addr];

endmodule

`default_nettype wire

// ==== design/alu_unit.sv ====
// --------------------------------------------------
// Single-cycle integer ALU
// Arithmetic, logic, compares and shifts
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int XLEN = 32
) (
    input  logic         clk,
    input  logic         rst_n,
    func_unit_ex_if.unit ex
);
    localparam int SHW = $clog2(XLEN);

    core_exec_pkg::alu_op_t op;
    logic [SHW-1:0]         shamt;
    logic [XLEN-1:0]        alu_out;

    assign op    = core_exec_pkg::alu_op_t'(ex.op);
    // Low log2(XLEN) bits only
    assign shamt = ex.rs2_data[SHW-1:0];

    always_comb begin
        case (op)
            core_exec_pkg::ALU_ADD:  alu_out = ex.rs1_data + ex.rs2_data;
            core_exec_pkg::ALU_SUB:  alu_out = ex.rs1_data - ex.rs2_data;
            core_exec_pkg::ALU_AND:  alu_out = ex.rs1_data & ex.rs2_data;
            core_exec_pkg::ALU_OR:   alu_out = ex.rs1_data | ex.rs2_data;
            core_exec_pkg::ALU_XOR:  alu_out = ex.rs1_data ^ ex.rs2_data;
            core_exec_pkg::ALU_SLT:  alu_out = XLEN'($signed(ex.rs1_data) < $signed(ex.rs2_data));
            core_exec_pkg::ALU_SLTU: alu_out = XLEN'(ex.rs1_data < ex.rs2_data);
            core_exec_pkg::ALU_SLL:  alu_out = ex.rs1_data << shamt;
            core_exec_pkg::ALU_SRL:  alu_out = ex.rs1_data >> shamt;
            core_exec_pkg::ALU_SRA:  alu_out = XLEN'($signed(ex.rs1_data) >>> shamt);
            default:                 alu_out = '0;
        endcase
    end

    // Result comes back the cycle after the request, so never busy
    assign ex.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.done <= 1'b0;
        end else begin
            ex.done <= ex.new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.new_request) begin
            ex.result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== design/div_unit.sv ====
// --------------------------------------------------
// Restoring shift-subtract divider at one bit per cycle
// DIV, DIVU, REM, REMU with RISC-V corner results
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int XLEN = 32
) (
    input  logic         clk,
    input  logic         rst_n,
    func_unit_ex_if.unit ex
);
    core_exec_pkg::div_op_t op_in;
    logic                   is_rem_q;
    logic                   a_neg;
    logic                   b_neg;
    logic [XLEN-1:0]        a_abs;
    logic [XLEN-1:0]        b_abs;
    logic [XLEN-1:0]        divisor_q;
    logic [XLEN-1:0]        quo_q;
    logic [XLEN-1:0]        rem_q;
    logic                   neg_quo_q;
    logic                   neg_rem_q;
    logic [XLEN:0]          shifted;
    logic [XLEN:0]          diff;
    logic [XLEN-1:0]        quo_next;
    logic [XLEN-1:0]        rem_next;
    logic [XLEN-1:0]        quo_final;
    logic [XLEN-1:0]        rem_final;
    logic                   timer_last;
    logic                   timer_busy;

    // Magnitudes of the operands for signed ops
    assign op_in = ex.op[1:0];
    assign a_neg = op_in.is_signed && ex.rs1_data[XLEN-1];
    assign b_neg = op_in.is_signed && ex.rs2_data[XLEN-1];
    assign a_abs = a_neg ? -ex.rs1_data : ex.rs1_data;
    assign b_abs = b_neg ? -ex.rs2_data : ex.rs2_data;

    iteration_timer #(
        .LENGTH(XLEN)
    ) i_iteration_timer (
        .clk  (clk),
        .rst_n(rst_n),
        .load (ex.new_request),
        .last (timer_last),
        .busy (timer_busy)
    );

    // One restoring step as dividend bits shift out of quo_q
    assign shifted  = {rem_q, quo_q[XLEN-1]};
    assign diff     = shifted - {1'b0, divisor_q};
    // Top bit of diff set means the subtract borrowed
    assign rem_next = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
    assign quo_next = {quo_q[XLEN-2:0], ~diff[XLEN]};

    // Sign fix after the last step
    assign quo_final = neg_quo_q ? -quo_next : quo_next;
    assign rem_final = neg_rem_q ? -rem_next : rem_next;

    always_ff @(posedge clk) begin
        if (ex.new_request) begin
            is_rem_q  <= op_in.is_rem;
            divisor_q <= b_abs;
            quo_q     <= a_abs;
            rem_q     <= '0;
            // Divide by zero keeps the all-ones quotient unsigned
            neg_quo_q <= (a_neg ^ b_neg) && (ex.rs2_data != '0);
            // Remainder takes the dividend sign so x/0 returns x
            neg_rem_q <= a_neg;
        end else if (timer_busy) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
        end
        // Most negative / -1 falls out as quotient = dividend and remainder 0
        if (timer_last) begin
            ex.result <= is_rem_q ? rem_final : quo_final;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.done  <= 1'b0;
            ex.ready <= 1'b1;
        end else begin
            ex.done <= timer_last;
            if (ex.new_request) begin
                ex.ready <= 1'b0;
            end else if (timer_last) begin
                ex.ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_control.sv ====
// --------------------------------------------------
// Control FSM for the four-phase fetch handshake
// Decode, issue to ALU or divider, writeback
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue_control #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_req,
    input  core_isa_pkg::instr_t instr,
    output logic                 instr_ack,
    output logic                 wb_valid,
    output logic                 illegal,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data,
    func_unit_ex_if.issue        alu_ex,
    func_unit_ex_if.issue        div_ex,
    rf_if.ctrl                   rf
);
    typedef enum logic [2:0] {IDLE, DECODE, ISSUE, WAIT, WRITE, ACK, RELEASE} state_t;

    state_t                state;
    core_exec_pkg::issue_t dec;
    core_exec_pkg::issue_t issue_q;
    logic                  dec_illegal;
    logic                  illegal_q;
    logic                  to_div;
    logic                  unit_ready;
    logic                  unit_done;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       result_q;

    // Decode straight off the request word, held stable until ack
    always_comb begin
        dec         = '0;
        dec.rd      = instr.r.rd;
        dec.imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        dec_illegal = 1'b0;
        case (instr.r.opcode)
            core_isa_pkg::OPC_OP: begin
                if (instr.r.funct7 == core_isa_pkg::FUNCT7_BASE) begin
                    case (instr.r.funct3)
                        core_isa_pkg::F3_ADD_SUB: dec.alu_op = core_exec_pkg::ALU_ADD;
                        core_isa_pkg::F3_SLL:     dec.alu_op = core_exec_pkg::ALU_SLL;
                        core_isa_pkg::F3_SLT:     dec.alu_op = core_exec_pkg::ALU_SLT;
                        core_isa_pkg::F3_SLTU:    dec.alu_op = core_exec_pkg::ALU_SLTU;
                        core_isa_pkg::F3_XOR:     dec.alu_op = core_exec_pkg::ALU_XOR;
                        core_isa_pkg::F3_SR:      dec.alu_op = core_exec_pkg::ALU_SRL;
                        core_isa_pkg::F3_OR:      dec.alu_op = core_exec_pkg::ALU_OR;
                        core_isa_pkg::F3_AND:     dec.alu_op = core_exec_pkg::ALU_AND;
                    endcase
                end else if (instr.r.funct7 == core_isa_pkg::FUNCT7_ALT) begin
                    // Only SUB and SRA live in the alternate group
                    if (instr.r.funct3 == core_isa_pkg::F3_ADD_SUB) begin
                        dec.alu_op = core_exec_pkg::ALU_SUB;
                    end else if (instr.r.funct3 == core_isa_pkg::F3_SR) begin
                        dec.alu_op = core_exec_pkg::ALU_SRA;
                    end else begin
                        dec_illegal = 1'b1;
                    end
                end else if (instr.r.funct7 == core_isa_pkg::FUNCT7_MULDIV) begin
                    dec.unit = core_exec_pkg::UNIT_DIV;
                    case (instr.r.funct3)
                        core_isa_pkg::F3_DIV:  dec.div_op = '{is_signed: 1'b1, is_rem: 1'b0};
                        core_isa_pkg::F3_DIVU: dec.div_op = '{is_signed: 1'b0, is_rem: 1'b0};
                        core_isa_pkg::F3_REM:  dec.div_op = '{is_signed: 1'b1, is_rem: 1'b1};
                        core_isa_pkg::F3_REMU: dec.div_op = '{is_signed: 1'b0, is_rem: 1'b1};
                        // MUL half of the M group is not built
                        default:               dec_illegal = 1'b1;
                    endcase
                end else begin
                    dec_illegal = 1'b1;
                end
            end
            core_isa_pkg::OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                case (instr.i.funct3)
                    core_isa_pkg::F3_ADD_SUB: dec.alu_op = core_exec_pkg::ALU_ADD;
                    core_isa_pkg::F3_SLT:     dec.alu_op = core_exec_pkg::ALU_SLT;
                    core_isa_pkg::F3_XOR:     dec.alu_op = core_exec_pkg::ALU_XOR;
                    core_isa_pkg::F3_OR:      dec.alu_op = core_exec_pkg::ALU_OR;
                    core_isa_pkg::F3_AND:     dec.alu_op = core_exec_pkg::ALU_AND;
                    default:                  dec_illegal = 1'b1;
                endcase
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    // Selected unit handshake
    assign to_div     = (issue_q.unit == core_exec_pkg::UNIT_DIV);
    assign unit_ready = to_div ? div_ex.ready : alu_ex.ready;
    assign unit_done  = to_div ? div_ex.done : alu_ex.done;

    // Immediate replaces rs2 for OP-IMM
    assign operand_b = issue_q.use_imm ? XLEN'($signed(issue_q.imm)) : rf.rs2_data;

    assign alu_ex.new_request = (state == ISSUE) && unit_ready && !to_div;
    assign alu_ex.op          = issue_q.alu_op;
    assign alu_ex.rs1_data    = rf.rs1_data;
    assign alu_ex.rs2_data    = operand_b;
    assign div_ex.new_request = (state == ISSUE) && unit_ready && to_div;
    assign div_ex.op          = {2'b00, issue_q.div_op};
    assign div_ex.rs1_data    = rf.rs1_data;
    assign div_ex.rs2_data    = operand_b;

    // Register file reads and the single write
    assign rf.rs1_addr = instr.r.rs1;
    assign rf.rs2_addr = instr.r.rs2;
    assign rf.we       = wb_valid;
    assign rf.rd       = issue_q.rd;
    assign rf.wdata    = result_q;

    // x0 writes and illegal words are silent
    assign wb_valid  = (state == WRITE) && !illegal_q && (issue_q.rd != 5'd0);
    assign wb_rd     = issue_q.rd;
    assign wb_data   = result_q;
    assign instr_ack = (state == ACK) || (state == RELEASE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            illegal_q <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            // Pulse lines up with the rising ack
            illegal <= (state == WRITE) && illegal_q;
            case (state)
                IDLE: begin
                    if (instr_req) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    illegal_q <= dec_illegal;
                    state     <= dec_illegal ? WRITE : ISSUE;
                end
                ISSUE: begin
                    if (unit_ready) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (unit_done) begin
                        state <= WRITE;
                    end
                end
                WRITE: state <= ACK;
                ACK: begin
                    if (!instr_req) begin
                        state <= RELEASE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Issue record and unit result
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            issue_q <= dec;
        end
        if ((state == WAIT) && unit_done) begin
            result_q <= to_div ? div_ex.result : alu_ex.result;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_core.sv ====
// --------------------------------------------------
// Execution back end top level
// Control FSM, ALU, divider and register file
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_req,
    input  logic [31:0]     instr,
    output logic            instr_ack,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [XLEN-1:0] wb_data,
    output logic            illegal
);
    // Unit execute links and register file access
    func_unit_ex_if #(.XLEN(XLEN)) alu_ex ();
    func_unit_ex_if #(.XLEN(XLEN)) div_ex ();
    rf_if #(.XLEN(XLEN)) rf ();

    issue_control #(
        .XLEN(XLEN)
    ) i_issue_control (.*);

    register_file #(
        .XLEN(XLEN)
    ) i_register_file (.*);

    alu_unit #(
        .XLEN(XLEN)
    ) i_alu_unit (.*, .ex(alu_ex));

    div_unit #(
        .XLEN(XLEN)
    ) i_div_unit (.*, .ex(div_ex));

endmodule

`default_nettype wire

// ==== verif/exec_core_tb.sv ====
// --------------------------------------------------
// Table-driven testbench for exec_core
// Four-phase request driver, writeback monitor
// Compare tasks and watchdog
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    localparam int XLEN = 32;

    // Short names for the funct7 groups
    localparam logic [6:0] F7B = core_isa_pkg::FUNCT7_BASE;
    localparam logic [6:0] F7A = core_isa_pkg::FUNCT7_ALT;
    localparam logic [6:0] F7M = core_isa_pkg::FUNCT7_MULDIV;

    // One table row where exp_rd of zero means no writeback
    typedef struct packed {
        logic [31:0]     word;
        logic            exp_illegal;
        logic [4:0]      exp_rd;
        logic [XLEN-1:0] exp_data;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            instr_req;
    logic [31:0]     instr;
    logic            instr_ack;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            illegal;

    row_t            rows[$];
    logic [4:0]      wb_rd_q[$];
    logic [XLEN-1:0] wb_data_q[$];
    logic            rows_loaded;
    logic            ack_prev;
    logic            req_prev;

    exec_core #(
        .XLEN(XLEN)
    ) i_exec_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr_req(instr_req),
        .instr    (instr),
        .instr_ack(instr_ack),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_wb(input logic [4:0] exp_rd, input logic [XLEN-1:0] exp_data,
                            input logic [4:0] got_rd, input logic [XLEN-1:0] got_data);
        if (got_rd !== exp_rd) begin
            abort_run($sformatf("FAILED at %0d ns: wb_rd expected %0d got %0d",
                                $time, exp_rd, got_rd));
        end
        if (got_data !== exp_data) begin
            abort_run($sformatf("FAILED at %0d ns: wb_data expected %h got %h",
                                $time, exp_data, got_data));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %b got %b",
                                $time, name, exp, got));
        end
    endtask

    // R-type word in assembly operand order
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], core_isa_pkg::OPC_OP};
    endfunction

    // I-type word keeping the low 12 bits of imm
    function automatic logic [31:0] i_word(input logic [2:0] f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], core_isa_pkg::OPC_OP_IMM};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic ill, input int rd,
                           input logic [XLEN-1:0] data);
        rows.push_back('{word: word, exp_illegal: ill, exp_rd: rd[4:0], exp_data: data});
    endtask

    // Expected results worked out by hand from the RV32 rules
    task automatic load_table();
        // Operands from x0
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 1, 0, 100), 1'b0, 1, 32'h0000_0064);
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 2, 0, -7), 1'b0, 2, 32'hffff_fff9);
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 3, 0, 3), 1'b0, 3, 32'h0000_0003);
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 4, 0, -1), 1'b0, 4, 32'hffff_ffff);
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 29, 0, 31), 1'b0, 29, 32'h0000_001f);
        // Register-register ALU
        add_row(r_word(F7B, core_isa_pkg::F3_ADD_SUB, 5, 1, 2), 1'b0, 5, 32'h0000_005d);
        // 3 - 100 wraps below zero
        add_row(r_word(F7A, core_isa_pkg::F3_ADD_SUB, 6, 3, 1), 1'b0, 6, 32'hffff_ff9f);
        // -7 against 3 as signed then unsigned
        add_row(r_word(F7B, core_isa_pkg::F3_SLT, 7, 2, 3), 1'b0, 7, 32'h0000_0001);
        add_row(r_word(F7B, core_isa_pkg::F3_SLTU, 8, 2, 3), 1'b0, 8, 32'h0000_0000);
        add_row(r_word(F7A, core_isa_pkg::F3_SR, 9, 2, 3), 1'b0, 9, 32'hffff_ffff);
        add_row(r_word(F7B, core_isa_pkg::F3_SR, 10, 2, 3), 1'b0, 10, 32'h1fff_ffff);
        add_row(r_word(F7B, core_isa_pkg::F3_SLL, 11, 1, 3), 1'b0, 11, 32'h0000_0320);
        add_row(r_word(F7B, core_isa_pkg::F3_AND, 12, 1, 2), 1'b0, 12, 32'h0000_0060);
        add_row(r_word(F7B, core_isa_pkg::F3_OR, 13, 1, 3), 1'b0, 13, 32'h0000_0067);
        add_row(r_word(F7B, core_isa_pkg::F3_XOR, 14, 1, 2), 1'b0, 14, 32'hffff_ff9d);
        // Immediate forms with sign-extended immediates
        add_row(i_word(core_isa_pkg::F3_AND, 15, 1, 15), 1'b0, 15, 32'h0000_0004);
        add_row(i_word(core_isa_pkg::F3_OR, 16, 1, -256), 1'b0, 16, 32'hffff_ff64);
        add_row(i_word(core_isa_pkg::F3_XOR, 17, 1, 2047), 1'b0, 17, 32'h0000_079b);
        add_row(i_word(core_isa_pkg::F3_SLT, 18, 2, -6), 1'b0, 18, 32'h0000_0001);
        // Most negative value in x28
        add_row(r_word(F7B, core_isa_pkg::F3_SLL, 28, 4, 29), 1'b0, 28, 32'h8000_0000);
        // Divides with mixed signs where the quotient rounds toward zero
        add_row(r_word(F7M, core_isa_pkg::F3_DIV, 19, 2, 3), 1'b0, 19, 32'hffff_fffe);
        add_row(r_word(F7M, core_isa_pkg::F3_REM, 20, 2, 3), 1'b0, 20, 32'hffff_ffff);
        add_row(r_word(F7M, core_isa_pkg::F3_DIVU, 21, 2, 3), 1'b0, 21, 32'h5555_5553);
        add_row(r_word(F7M, core_isa_pkg::F3_REMU, 22, 1, 3), 1'b0, 22, 32'h0000_0001);
        add_row(r_word(F7M, core_isa_pkg::F3_DIV, 23, 1, 2), 1'b0, 23, 32'hffff_fff2);
        add_row(r_word(F7M, core_isa_pkg::F3_REM, 24, 1, 2), 1'b0, 24, 32'h0000_0002);
        // Divide by zero
        add_row(r_word(F7M, core_isa_pkg::F3_DIV, 25, 1, 0), 1'b0, 25, 32'hffff_ffff);
        add_row(r_word(F7M, core_isa_pkg::F3_REM, 26, 2, 0), 1'b0, 26, 32'hffff_fff9);
        add_row(r_word(F7M, core_isa_pkg::F3_DIVU, 27, 1, 0), 1'b0, 27, 32'hffff_ffff);
        // Signed overflow as most negative over -1
        add_row(r_word(F7M, core_isa_pkg::F3_DIV, 30, 28, 4), 1'b0, 30, 32'h8000_0000);
        add_row(r_word(F7M, core_isa_pkg::F3_REM, 31, 28, 4), 1'b0, 31, 32'h0000_0000);
        // MUL x5 and LUI x5 are not built so x5 keeps 0x5d
        add_row(r_word(F7M, 3'b000, 5, 1, 3), 1'b1, 0, '0);
        add_row(32'h1234_52b7, 1'b1, 0, '0);
        add_row(r_word(F7B, core_isa_pkg::F3_ADD_SUB, 6, 5, 0), 1'b0, 6, 32'h0000_005d);
        // SLLI is outside the set so x8 stays zero
        add_row(i_word(core_isa_pkg::F3_SLL, 8, 1, 2), 1'b1, 0, '0);
        add_row(r_word(F7B, core_isa_pkg::F3_ADD_SUB, 9, 8, 0), 1'b0, 9, 32'h0000_0000);
        // Write to x0 is dropped and x0 still reads zero
        add_row(i_word(core_isa_pkg::F3_ADD_SUB, 0, 1, 5), 1'b0, 0, '0);
        add_row(r_word(F7B, core_isa_pkg::F3_ADD_SUB, 7, 0, 1), 1'b0, 7, 32'h0000_0064);
    endtask

    // Records writebacks and watches the four-phase rule
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_valid) begin
                wb_rd_q.push_back(wb_rd);
                wb_data_q.push_back(wb_data);
            end
            if (instr_ack && !ack_prev && !req_prev) begin
                abort_run($sformatf("instr_ack rose at %0d ns with no request", $time));
            end
            if (!instr_ack && ack_prev && req_prev) begin
                abort_run($sformatf("instr_ack fell at %0d ns while instr_req high", $time));
            end
        end
        ack_prev = instr_ack;
        req_prev = instr_req;
    end

    // One full handshake for one row
    task automatic run_row(input row_t row);
        int              gap;
        logic [4:0]      got_rd;
        logic [XLEN-1:0] got_data;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #1;
        instr     = row.word;
        instr_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!instr_ack);
        // illegal pulses together with the rising ack
        check_flag("illegal", row.exp_illegal, illegal);
        if (row.exp_rd == 5'd0) begin
            if (wb_rd_q.size() != 0) begin
                abort_run($sformatf("word %h wrote back to x%0d but should not write",
                                    row.word, wb_rd_q[0]));
            end
        end else if (wb_rd_q.size() != 1) begin
            abort_run($sformatf("word %h gave %0d writebacks instead of one",
                                row.word, wb_rd_q.size()));
        end else begin
            got_rd   = wb_rd_q.pop_front();
            got_data = wb_data_q.pop_front();
            check_wb(row.exp_rd, row.exp_data, got_rd, got_data);
        end
        // Request stays up a while so ack has to hold
        repeat (2) begin
            @(posedge clk);
            #1;
            check_flag("instr_ack", 1'b1, instr_ack);
            check_flag("illegal", 1'b0, illegal);
        end
        instr_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (instr_ack);
    endtask

    // Bound grows with the table length
    initial begin
        wait (rows_loaded);
        repeat (rows.size() * (XLEN + 20) + 20) @(posedge clk);
        abort_run("timeout, a handshake never completed");
    end

    initial begin
        void'($urandom(32'hc69e_65d4));
        rst_n       = 1'b0;
        instr_req   = 1'b0;
        instr       = '0;
        ack_prev    = 1'b0;
        req_prev    = 1'b0;
        rows_loaded = 1'b0;
        load_table();
        rows_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("instr_ack", 1'b0, instr_ack);
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("illegal", 1'b0, illegal);
        for (int n = 0; n < rows.size(); n++) begin
            run_row(rows[n]);
        end
        // Let any stray pulse reach the monitor
        repeat (4) @(posedge clk);
        #1;
        if (wb_rd_q.size() != 0) begin
            abort_run("writeback seen after the last instruction");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/core_isa_pkg.sv
design/core_exec_pkg.sv
design/exec_ifs.sv
design/iteration_timer.sv
design/register_file.sv
design/alu_unit.sv
design/div_unit.sv
design/issue_control.sv
design/exec_core.sv
verif/exec_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build exec_core_tb with Verilator, run it, scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module exec_core_tb \
    -f project.f -Mdir obj_dir -o exec_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0
